// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_lockin
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' all.f)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

# Rebuilt only when the file list or a source changes
$(BIN): all.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP) -f all.f

clean:
	rm -rf $(BUILD_DIR)

// ==== all.f ====
design/lockin_pkg.sv
design/lockin_decimator.sv
design/lockin_window.sv
design/lockin_magnitude.sv
design/lockin_top.sv
testbench/tb_lockin.sv

// ==== design/lockin_decimator.sv ====
`timescale 1ns/1ns

module lockin_decimator #(
    parameter int buf_len2  = 10,
    parameter int decim_max = 16
) (
    input  logic                                     a_clk,
    input  logic                                     reset,
    input  logic [lockin_pkg::sig_width-1:0]         sig_tdata,
    input  logic [lockin_pkg::sc_word_width-1:0]     sc_tdata,
    input  logic [lockin_pkg::period_width-1:0]      period_log2,
    output logic signed [lockin_pkg::corr_width-1:0] prod_x,
    output logic signed [lockin_pkg::corr_width-1:0] prod_y,
    output logic                                     prod_strobe,
    output logic [$clog2(buf_len2+1)-1:0]            window_log2,
    output logic                                     period_change,
    output logic [lockin_pkg::ref_width-1:0]         sref,
    output logic [lockin_pkg::ref_width-1:0]         sdref
);
    import lockin_pkg::*;

    localparam int dw     = $clog2(decim_max + 1);  // Decimation exponent bits
    localparam int ww     = $clog2(buf_len2 + 1);
    localparam int acc_w  = sig_q_width + decim_max;  // Group sum, no overflow
    localparam int prod_w = sig_q_width + sc_width;

    logic [period_width-1:0]       per_reg;
    logic [period_width-1:0]       per_last;    // Last period seen
    logic [period_width-1:0]       decim_diff;
    logic                          per_changed;
    logic [dw-1:0]                 decim_log2;
    logic [dw-1:0]                 decim_new;
    logic [ww-1:0]                 window_new;
    logic signed [sig_q_width-1:0] sig_in;
    logic signed [sc_width-1:0]    s_in;
    logic signed [sc_width-1:0]    c_in;
    logic [decim_max-1:0]          grp_cnt;     // Samples left in group
    logic signed [acc_w-1:0]       acc;
    logic signed [acc_w-1:0]       acc_next;
    logic signed [acc_w-1:0]       avg_full;
    logic signed [sig_q_width-1:0] avg;         // Group average
    logic signed [sc_width-1:0]    s_grp;       // Reference at group end
    logic signed [sc_width-1:0]    c_grp;
    logic                          avg_vld;
    logic signed [prod_w-1:0]      mul_x;
    logic signed [prod_w-1:0]      mul_y;
    logic                          mul_vld;

    // Reload value for a group of 2**e samples
    function automatic logic [decim_max-1:0] group_last(input logic [dw-1:0] e);
        return decim_max'((33'd1 << e) - 33'd1);
    endfunction

    ////////////////////////////
    // Period split
    ////////////////////////////
    always_comb
    begin
        per_changed = (per_reg != per_last);
        decim_diff  = per_reg - period_width'(buf_len2);
        if (per_reg > period_width'(buf_len2))
        begin
            if (decim_diff > period_width'(decim_max))
                decim_new = dw'(decim_max);   // Clamp long periods
            else
                decim_new = dw'(decim_diff);
            window_new = ww'(buf_len2);      // Window fills whole memory
        end
        else
        begin
            decim_new  = '0;                  // No decimation needed
            window_new = ww'(per_reg);
        end
    end

    assign acc_next = acc + acc_w'(sig_in);      // Sign-extended add
    assign avg_full = acc_next >>> decim_log2;   // Arithmetic, keeps sign

    // Input capture
    always_ff @(posedge a_clk)
    begin
        sig_in <= sig_tdata[sig_width-1 -: sig_q_width];  // Top bits only
        c_in   <= sc_tdata[sc_width-1:0];
        s_in   <= sc_tdata[sc_word_width/2 +: sc_width];
    end

    ////////////////////////////
    // Group control
    ////////////////////////////
    always_ff @(posedge a_clk)
    begin
        if (reset)
        begin
            per_reg       <= '0;
            per_last      <= '0;
            decim_log2    <= '0;
            window_log2   <= '0;
            period_change <= 1'b0;
            grp_cnt       <= '0;
            acc           <= '0;
            avg_vld       <= 1'b0;
            mul_vld       <= 1'b0;
            prod_strobe   <= 1'b0;
        end
        else
        begin
            per_reg       <= period_log2;
            period_change <= per_changed;
            prod_strobe   <= mul_vld;
            if (per_changed)
            begin
                // Both exponents from the new period, group restarts
                per_last    <= per_reg;
                decim_log2  <= decim_new;
                window_log2 <= window_new;
                grp_cnt     <= group_last(decim_new);
                acc         <= '0;
                avg_vld     <= 1'b0;  // Flush partial work
                mul_vld     <= 1'b0;
            end
            else
            begin
                mul_vld <= avg_vld;
                avg_vld <= (grp_cnt == '0);
                if (grp_cnt == '0)
                begin
                    grp_cnt <= group_last(decim_log2);  // Reload
                    acc     <= '0;                      // Start new sum
                end
                else
                begin
                    grp_cnt <= grp_cnt - 1'b1;
                    acc     <= acc_next;
                end
            end
        end
    end

    // Average, product, normalize
    always_ff @(posedge a_clk)
    begin
        if (grp_cnt == '0)
        begin
            avg   <= avg_full[sig_q_width-1:0];
            s_grp <= s_in;
            c_grp <= c_in;
        end
        mul_x  <= s_grp * avg;  // In-phase
        mul_y  <= c_grp * avg;  // Quadrature
        prod_x <= corr_width'(mul_x >>> corr_shift);
        prod_y <= corr_width'(mul_y >>> corr_shift);
    end

    assign sref  = ref_width'(c_in);   // Sign-extended cosine
    assign sdref = ref_width'(s_grp);  // Sine at group boundary

endmodule

// ==== design/lockin_magnitude.sv ====
`timescale 1ns/1ns

module lockin_magnitude #(
    parameter int buf_len2 = 10
) (
    input  logic                                              a_clk,
    input  logic                                              reset,
    input  logic signed [lockin_pkg::corr_width+buf_len2-1:0] sum_x,
    input  logic signed [lockin_pkg::corr_width+buf_len2-1:0] sum_y,
    input  logic                                              sum_strobe,
    input  logic                                              window_full,
    input  logic [$clog2(buf_len2+1)-1:0]                     window_log2,
    output logic [lockin_pkg::ampl_width-1:0]                 ampl2,
    output logic signed [lockin_pkg::mean_width-1:0]          mean_sum,
    output logic signed [lockin_pkg::mean_width-1:0]          mean_diff,
    output logic                                              out_valid,
    output logic                                              out_settled
);
    import lockin_pkg::*;

    localparam int sum_w = corr_width + buf_len2;

    logic signed [sum_w-1:0]        norm_x;
    logic signed [sum_w-1:0]        norm_y;
    logic signed [corr_width-1:0]   a;       // In-phase mean
    logic signed [corr_width-1:0]   b;       // Quadrature mean
    logic signed [2*corr_width-1:0] sq_a;
    logic signed [2*corr_width-1:0] sq_b;
    logic                           mean_vld;
    logic                           full_d;  // Window full at the means stage

    assign norm_x = sum_x >>> window_log2;  // Divide by window length
    assign norm_y = sum_y >>> window_log2;
    assign sq_a   = a * a;
    assign sq_b   = b * b;

    // Means and results
    always_ff @(posedge a_clk)
    begin
        if (sum_strobe)
        begin
            a <= corr_width'(norm_x);
            b <= corr_width'(norm_y);
        end
        if (mean_vld)
        begin
            ampl2     <= ampl_width'(sq_a + sq_b);  // Never negative
            mean_sum  <= mean_width'(a) + mean_width'(b);
            mean_diff <= mean_width'(a) - mean_width'(b);
        end
    end

    // Strobes and settled flag
    always_ff @(posedge a_clk)
    begin
        if (reset)
        begin
            mean_vld    <= 1'b0;
            full_d      <= 1'b0;
            out_valid   <= 1'b0;
            out_settled <= 1'b0;
        end
        else
        begin
            mean_vld    <= sum_strobe;
            full_d      <= window_full;
            out_valid   <= mean_vld;
            // Rises with the first full-window output
            out_settled <= full_d && window_full;  // Falls once the window clears
        end
    end

endmodule

// ==== design/lockin_pkg.sv ====
package lockin_pkg;

    ////////////////////////////
    // Input words
    ////////////////////////////
    localparam int sig_width     = 32;  // Raw ADC word
    localparam int sig_q_width   = 24;  // Top bits kept for lock-in
    localparam int sc_word_width = 64;  // Packed sin/cos word
    localparam int sc_width      = 25;  // Q1.24, signed
    localparam int period_width  = 16;  // Period exponent input

    ////////////////////////////
    // Correlation precision
    ////////////////////////////
    localparam int corr_width = 32;     // Normalized product and mean

    // Full product is sig_q_width + sc_width bits
    localparam int corr_shift = sig_q_width + sc_width - corr_width;

    // Result words
    localparam int ampl_width = 2 * corr_width - 1;  // a*a + b*b, unsigned
    localparam int mean_width = corr_width + 2;      // Headroom for a +/- b
    localparam int ref_width  = 32;                  // Sign-extended reference taps

endpackage

// ==== design/lockin_top.sv ====
`timescale 1ns/1ns

module lockin_top #(
    parameter int buf_len2  = 10,  // log2 of window memory depth
    parameter int decim_max = 16   // Largest decimation exponent
) (
    input  logic                                     a_clk,
    input  logic                                     reset,
    input  logic [lockin_pkg::sig_width-1:0]         sig_tdata,
    input  logic [lockin_pkg::sc_word_width-1:0]     sc_tdata,
    input  logic [lockin_pkg::period_width-1:0]      period_log2,
    output logic [lockin_pkg::ampl_width-1:0]        ampl2,
    output logic signed [lockin_pkg::mean_width-1:0] mean_sum,
    output logic signed [lockin_pkg::mean_width-1:0] mean_diff,
    output logic                                     out_valid,
    output logic                                     out_settled,
    output logic [lockin_pkg::ref_width-1:0]         sref,
    output logic [lockin_pkg::ref_width-1:0]         sdref
);
    import lockin_pkg::*;

    localparam int ww = $clog2(buf_len2 + 1);

    // Producer to buffer
    logic signed [corr_width-1:0] prod_x;
    logic signed [corr_width-1:0] prod_y;
    logic                         prod_strobe;
    logic [ww-1:0]                window_log2;
    logic                         period_change;

    // Buffer to consumer
    logic signed [corr_width+buf_len2-1:0] sum_x;
    logic signed [corr_width+buf_len2-1:0] sum_y;
    logic                                  sum_strobe;
    logic                                  window_full;

    //////////////////////////////
    // Decimate and correlate
    lockin_decimator #(.buf_len2(buf_len2), .decim_max(decim_max)) u_decimator (
        .a_clk(a_clk), .reset(reset),
        .sig_tdata(sig_tdata), .sc_tdata(sc_tdata), .period_log2(period_log2),
        .prod_x(prod_x), .prod_y(prod_y), .prod_strobe(prod_strobe),
        .window_log2(window_log2), .period_change(period_change),
        .sref(sref), .sdref(sdref)
    );

    // One-period moving window
    lockin_window #(.buf_len2(buf_len2)) u_window (
        .a_clk(a_clk), .reset(reset),
        .prod_x(prod_x), .prod_y(prod_y), .prod_strobe(prod_strobe),
        .window_log2(window_log2), .period_change(period_change),
        .sum_x(sum_x), .sum_y(sum_y), .sum_strobe(sum_strobe), .window_full(window_full)
    );

    // Means and amplitude
    lockin_magnitude #(.buf_len2(buf_len2)) u_magnitude (
        .a_clk(a_clk), .reset(reset),
        .sum_x(sum_x), .sum_y(sum_y), .sum_strobe(sum_strobe),
        .window_full(window_full), .window_log2(window_log2),
        .ampl2(ampl2), .mean_sum(mean_sum), .mean_diff(mean_diff),
        .out_valid(out_valid), .out_settled(out_settled)
    );

endmodule

// ==== design/lockin_window.sv ====
`timescale 1ns/1ns

module lockin_window #(
    parameter int buf_len2 = 10
) (
    input  logic                                              a_clk,
    input  logic                                              reset,
    input  logic signed [lockin_pkg::corr_width-1:0]          prod_x,
    input  logic signed [lockin_pkg::corr_width-1:0]          prod_y,
    input  logic                                              prod_strobe,
    input  logic [$clog2(buf_len2+1)-1:0]                     window_log2,
    input  logic                                              period_change,
    output logic signed [lockin_pkg::corr_width+buf_len2-1:0] sum_x,
    output logic signed [lockin_pkg::corr_width+buf_len2-1:0] sum_y,
    output logic                                              sum_strobe,
    output logic                                              window_full
);
    import lockin_pkg::*;

    localparam int depth = 1 << buf_len2;
    localparam int sum_w = corr_width + buf_len2;

    // Product history, one period deep at most
    logic signed [corr_width-1:0] mem_x [depth];
    logic signed [corr_width-1:0] mem_y [depth];

    logic [buf_len2-1:0]          wr_idx;
    logic [buf_len2-1:0]          win_mask;
    logic [buf_len2:0]            win_len;    // Products per period
    logic [buf_len2:0]            fill_cnt;   // Saturates at win_len
    logic signed [corr_width-1:0] new_x;
    logic signed [corr_width-1:0] new_y;
    logic signed [corr_width-1:0] old_x;      // Product leaving window
    logic signed [corr_width-1:0] old_y;
    logic                         rd_vld;
    logic                         drop_old;
    logic signed [sum_w-1:0]      drop_x;
    logic signed [sum_w-1:0]      drop_y;

    assign win_len  = (buf_len2 + 1)'(1) << window_log2;
    assign win_mask = buf_len2'(win_len - 1'b1);

    always_comb
    begin
        if (drop_old)
        begin
            drop_x = sum_w'(old_x);
            drop_y = sum_w'(old_y);
        end
        else
        begin
            drop_x = '0;  // Window still filling
            drop_y = '0;
        end
    end

    ////////////////////////////
    // Memory, read before write
    ////////////////////////////
    always_ff @(posedge a_clk)
    begin
        if (prod_strobe)
        begin
            old_x         <= mem_x[wr_idx];  // Written one period ago
            old_y         <= mem_y[wr_idx];
            mem_x[wr_idx] <= prod_x;
            mem_y[wr_idx] <= prod_y;
            new_x         <= prod_x;
            new_y         <= prod_y;
        end
    end

    ////////////////////////////
    // Moving sums
    ////////////////////////////
    always_ff @(posedge a_clk)
    begin
        if (reset || period_change)
        begin
            // New period, stale memory is masked by fill_cnt
            wr_idx      <= '0;
            fill_cnt    <= '0;
            rd_vld      <= 1'b0;
            drop_old    <= 1'b0;
            sum_x       <= '0;
            sum_y       <= '0;
            sum_strobe  <= 1'b0;
            window_full <= 1'b0;
        end
        else
        begin
            rd_vld     <= prod_strobe;
            sum_strobe <= rd_vld;
            if (prod_strobe)
            begin
                wr_idx   <= (wr_idx + 1'b1) & win_mask;  // Wrap at window length
                drop_old <= (fill_cnt == win_len);
                if (fill_cnt != win_len)
                    fill_cnt <= fill_cnt + 1'b1;
            end
            if (rd_vld)
            begin
                sum_x       <= sum_x + sum_w'(new_x) - drop_x;
                sum_y       <= sum_y + sum_w'(new_y) - drop_y;
                window_full <= (fill_cnt == win_len);  // Count includes this one
            end
        end
    end

endmodule

// ==== testbench/lockin_stimulus.txt ====
# period_log2 sig[31:8] sine cosine alt count(dec) ampl2 mean_sum mean_diff, others hex
# alt=1 flips the sine sign at each decimation boundary
3 010000 0800000 0400000 0 40 140000000000 000600000 000200000
6 030000 0400000 1c00000 0 100 480000000000 000000000 000c00000
4 010000 0800000 0200000 1 48 010000000000 000100000 3fff00000
2 100000 0100000 0080000 0 24 500000000000 000c00000 000400000
5 fe0000 1800000 0c00000 0 60 d00000000000 3ffc00000 001400000
9 040000 1000000 0ffffff 0 170 7fffff8000004 3fffffffe 3fc000002

// ==== testbench/tb_lockin.sv ====
`timescale 1ns/1ns

module tb_lockin;
    localparam int buf_len2  = 4;  // Small memory keeps decimated cases short
    localparam int decim_max = 3;  // Low clamp that the last case reaches
    localparam int clk_ns    = 4;

    // One stimulus line
    typedef struct {
        logic [15:0] per;
        logic [23:0] sig;       // Top signal bits
        logic [24:0] sin;
        logic [24:0] cos;
        logic        alt;       // Sine flips per decimation group
        int          cnt;
        logic [62:0] ampl_exp;
        logic [33:0] sum_exp;
        logic [33:0] diff_exp;
    } case_t;

    logic               a_clk = 1'b0;
    logic               reset;
    logic [31:0]        sig_tdata;
    logic [63:0]        sc_tdata;
    logic [15:0]        period_log2;
    logic [62:0]        ampl2;
    logic signed [33:0] mean_sum;
    logic signed [33:0] mean_diff;
    logic               out_valid;
    logic               out_settled;
    logic [31:0]        sref;
    logic [31:0]        sdref;

    case_t       cases[$];
    logic [31:0] lfsr = 32'h0ca91ff1;
    logic [24:0] cos_driven;              // Cosine seen by the last clock
    int          mismatches = 0;
    int          failures   = 0;
    int          limit_ns   = 0;
    int          total;
    logic        seen_low;                // Settled flag dropped this case
    int          unsettled;               // Outputs while not settled
    int          n_settled;
    logic [62:0] got_ampl;
    logic [33:0] got_sum;
    logic [33:0] got_diff;

    lockin_top #(.buf_len2(buf_len2), .decim_max(decim_max)) DUT (
        .a_clk(a_clk), .reset(reset), .sig_tdata(sig_tdata), .sc_tdata(sc_tdata),
        .period_log2(period_log2), .ampl2(ampl2), .mean_sum(mean_sum),
        .mean_diff(mean_diff), .out_valid(out_valid), .out_settled(out_settled),
        .sref(sref), .sdref(sdref)
    );

    // Galois step with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] sign_extend(input logic [24:0] v);
        return {{7{v[24]}}, v};
    endfunction

    // Decimation part of the period split
    function automatic int decim_exp(input int p);
        if (p <= buf_len2)
            return 0;
        return (p - buf_len2 > decim_max) ? decim_max : p - buf_len2;
    endfunction

    task automatic load_cases();
        int    fd;
        string line;
        case_t c;
        fd = $fopen("testbench/lockin_stimulus.txt", "r");
        assert (fd != 0)
        else
        begin
            $display("Cannot open the stimulus file");
            failures++;
        end
        while (fd != 0 && $fgets(line, fd) > 0)
        begin
            if (line.len() > 1 && line[0] != 8'h23)  // Skip comment lines
                if ($sscanf(line, "%h %h %h %h %h %d %h %h %h", c.per, c.sig, c.sin,
                            c.cos, c.alt, c.cnt, c.ampl_exp, c.sum_exp, c.diff_exp) == 9)
                    cases.push_back(c);
        end
        if (fd != 0)
            $fclose(fd);
        assert (cases.size() > 0)
        else
        begin
            $display("No test cases were read");
            failures++;
        end
    endtask

    task automatic drive_sample(input case_t c, input int idx);
        logic [7:0]  low;
        logic [24:0] s;
        for (int b = 0; b < 8; b++)
        begin
            lfsr   = lfsr_next(lfsr);  // One step per bit
            low[b] = lfsr[0];
        end
        s = c.sin;
        if (c.alt && ((idx >> decim_exp(int'(c.per))) & 1) == 1)
            s = -c.sin;
        sig_tdata   = {c.sig, low};    // Low byte is dropped by the DUT
        sc_tdata    = {7'd0, s, 7'd0, c.cos};
        period_log2 = c.per;
        cos_driven  = c.cos;
    endtask

    task automatic watch_outputs(input case_t c);
        int win;
        win = 1 << ((c.per > buf_len2) ? buf_len2 : int'(c.per));
        assert (sref == sign_extend(cos_driven))
        else
        begin
            $display("MISMATCH sref: got %h, expected %h", sref, sign_extend(cos_driven));
            mismatches++;
        end
        if (out_valid && out_settled && seen_low)
        begin
            if (n_settled == 0)
            begin
                // First settled output closes the first full window
                assert (unsettled >= win - 1)
                else
                begin
                    $display("Settled after only %0d outputs, window %0d", unsettled, win);
                    failures++;
                end
            end
            if (!c.alt)
            begin
                assert (sdref == sign_extend(c.sin))
                else
                begin
                    $display("MISMATCH sdref: got %h, expected %h", sdref, sign_extend(c.sin));
                    mismatches++;
                end
            end
            got_ampl = ampl2;
            got_sum  = mean_sum;
            got_diff = mean_diff;
            n_settled++;
        end
        else if (out_valid && !out_settled)
            unsettled++;
        if (!out_settled)
            seen_low = 1'b1;
    endtask

    task automatic check_case(input case_t c, input int k);
        assert (n_settled > 0)
        else
        begin
            $display("Case %0d ended with no settled output", k);
            failures++;
        end
        if (n_settled > 0)
        begin
            assert (got_ampl == c.ampl_exp)
            else
            begin
                $display("MISMATCH ampl2: got %h, expected %h", got_ampl, c.ampl_exp);
                mismatches++;
            end
            assert (got_sum == c.sum_exp)
            else
            begin
                $display("MISMATCH mean_sum: got %h, expected %h", got_sum, c.sum_exp);
                mismatches++;
            end
            assert (got_diff == c.diff_exp)
            else
            begin
                $display("MISMATCH mean_diff: got %h, expected %h", got_diff, c.diff_exp);
                mismatches++;
            end
        end
    endtask

    initial
    begin
        forever #(clk_ns / 2) a_clk = ~a_clk;
    end

    // Watchdog sized from the sample counts
    initial
    begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("Timeout after %0d ns, the run did not finish", limit_ns);
        $display("Checks failed");
        $finish;
    end

    initial
    begin
        reset       = 1'b1;
        sig_tdata   = '0;
        sc_tdata    = '0;
        period_log2 = '0;
        cos_driven  = '0;
        load_cases();
        total = 0;
        foreach (cases[k])
            total += cases[k].cnt;
        limit_ns = (total + 100) * clk_ns;    // Reset and pipeline margin
        repeat (4) @(negedge a_clk);
        reset = 1'b0;
        foreach (cases[k])
        begin
            seen_low  = 1'b0;                 // Every case starts with a period change
            unsettled = 0;
            n_settled = 0;
            for (int i = 0; i < cases[k].cnt; i++)
            begin
                @(negedge a_clk);
                watch_outputs(cases[k]);
                drive_sample(cases[k], i);
            end
            check_case(cases[k], k);
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule
